/* hdl/river_lite_pkg.sv */
// ISA constants, opcode and ALU enums shared by all river_lite RTL stages and the testbench
`default_nettype none

package river_lite_pkg;

    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;
    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_0000;
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    // funct3 / funct7 codes of the supported subset
    localparam logic [2:0] F3_ADD  = 3'b000;   // ADD, SUB, ADDI
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5     // LUI immediate, store data
    } alu_op_e;

    typedef enum logic [2:0] {
        IDLE,
        REQ,                  // Control request pending
        WAIT,                 // Waiting for instruction word
        BUSY,                 // Instruction in flight
        HALT
    } fetch_state_e;

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
// Fetch stage: owns the PC and the control-path handshake, hands one instruction at a time to decode
`default_nettype none

module fetch_unit
(
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_req_ctrl_ready,
    output logic                             o_req_ctrl_valid,
    output logic [river_lite_pkg::XLEN-1:0]  o_req_ctrl_addr,
    input  logic                             i_resp_ctrl_valid,
    input  logic [river_lite_pkg::XLEN-1:0]  i_resp_ctrl_data,
    output logic                             o_resp_ctrl_ready,
    output logic                             o_instr_valid,
    output logic [river_lite_pkg::XLEN-1:0]  o_instr_word,
    input  logic                             i_wb_done,     // Result stage finished
    input  logic                             i_illegal,     // Decode rejected the word
    output logic                             o_halted
);

import river_lite_pkg::*;

fetch_state_e    state;
logic [XLEN-1:0] pc;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        state <= IDLE;
        pc    <= RESET_PC;
    end
    else
    begin
        case (state)
        IDLE: state <= REQ;
        REQ:  if (i_req_ctrl_ready) state <= WAIT;
        WAIT: if (i_resp_ctrl_valid) state <= BUSY;
        BUSY:
        begin
            if (i_illegal)
                state <= HALT;           // Sticky until reset
            else if (i_wb_done)
            begin
                pc    <= pc + INSTR_BYTES;
                state <= REQ;
            end
        end
        HALT:    state <= HALT;
        default: state <= IDLE;
        endcase
    end
end

assign o_req_ctrl_valid  = (state == REQ);
assign o_req_ctrl_addr   = pc;
assign o_resp_ctrl_ready = (state == WAIT);
assign o_halted          = (state == HALT);

// Word goes to decode in the acceptance cycle, decode registers it
assign o_instr_valid = o_resp_ctrl_ready & i_resp_ctrl_valid;
assign o_instr_word  = i_resp_ctrl_data;

a_req_addr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_req_ctrl_valid && !i_req_ctrl_ready |=> o_req_ctrl_valid && $stable(o_req_ctrl_addr));

endmodule

`default_nettype wire

/* hdl/instr_decode.sv */
// Decode stage: splits the instruction word into register indices, immediate and ALU control
`default_nettype none

module instr_decode
(
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  logic                                     i_instr_valid,
    input  logic [river_lite_pkg::XLEN-1:0]          i_instr_word,
    output logic                                     o_dec_valid,
    output logic [river_lite_pkg::REG_ADDR_BITS-1:0] o_rs1,
    output logic [river_lite_pkg::REG_ADDR_BITS-1:0] o_rs2,
    output logic [river_lite_pkg::REG_ADDR_BITS-1:0] o_rd,
    output logic [river_lite_pkg::XLEN-1:0]          o_imm,
    output logic                                     o_use_imm,
    output river_lite_pkg::alu_op_e                  o_alu_op,
    output logic                                     o_is_store,
    output logic                                     o_illegal
);

import river_lite_pkg::*;

opcode_e         opcode;
logic [2:0]      funct3;
logic [6:0]      funct7;
logic [XLEN-1:0] imm_i;
logic [XLEN-1:0] imm_s;
logic [XLEN-1:0] imm_u;
logic            dec_ok;
alu_op_e         alu_op;
logic            use_imm;
logic            is_store;
logic [XLEN-1:0] imm;

assign opcode = opcode_e'(i_instr_word[6:0]);
assign funct3 = i_instr_word[14:12];
assign funct7 = i_instr_word[31:25];

assign imm_i = {{20{i_instr_word[31]}}, i_instr_word[31:20]};
assign imm_s = {{20{i_instr_word[31]}}, i_instr_word[31:25], i_instr_word[11:7]};
assign imm_u = {i_instr_word[31:12], 12'h000};

always_comb
begin
    dec_ok   = 1'b1;
    alu_op   = ALU_ADD;
    use_imm  = 1'b1;
    is_store = 1'b0;
    imm      = imm_i;
    case (opcode)
    OPC_OP_IMM:
    begin
        case (funct3)
        F3_ADD:  alu_op = ALU_ADD;
        F3_XOR:  alu_op = ALU_XOR;
        F3_OR:   alu_op = ALU_OR;
        F3_AND:  alu_op = ALU_AND;
        default: dec_ok = 1'b0;  // Shifts, compares not supported
        endcase
    end
    OPC_OP:
    begin
        use_imm = 1'b0;
        case ({funct7, funct3})
        {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
        {F7_SUB, F3_ADD}:  alu_op = ALU_SUB;
        {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
        {F7_BASE, F3_OR}:  alu_op = ALU_OR;
        {F7_BASE, F3_AND}: alu_op = ALU_AND;
        default:           dec_ok = 1'b0;
        endcase
    end
    OPC_LUI:
    begin
        alu_op = ALU_PASS_B;
        imm    = imm_u;
    end
    OPC_STORE:
    begin
        // Word stores only, operand B carries rs2 as data
        dec_ok   = (funct3 == F3_SW);
        alu_op   = ALU_PASS_B;
        use_imm  = 1'b0;
        is_store = 1'b1;
        imm      = imm_s;
    end
    default: dec_ok = 1'b0;
    endcase
end

always_ff @(posedge i_clk or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        o_dec_valid <= 1'b0;
        o_illegal   <= 1'b0;
    end
    else
    begin
        o_dec_valid <= i_instr_valid & dec_ok;
        o_illegal   <= i_instr_valid & ~dec_ok;
    end
end

always_ff @(posedge i_clk)
begin
    if (i_instr_valid)
    begin
        o_rs1      <= i_instr_word[19:15];
        o_rs2      <= i_instr_word[24:20];
        o_rd       <= i_instr_word[11:7];
        o_imm      <= imm;
        o_use_imm  <= use_imm;
        o_alu_op   <= alu_op;
        o_is_store <= is_store;
    end
end

// Each accepted word yields exactly one of the two pulses
a_one_outcome: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_instr_valid |=> (o_dec_valid != o_illegal));

endmodule

`default_nettype wire

/* hdl/int_execute.sv */
// Execute stage: reads operands from the register file and computes ALU result or store address
`default_nettype none

module int_execute
(
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  logic                                     i_dec_valid,
    input  logic [river_lite_pkg::REG_ADDR_BITS-1:0] i_rs1,
    input  logic [river_lite_pkg::REG_ADDR_BITS-1:0] i_rs2,
    input  logic [river_lite_pkg::REG_ADDR_BITS-1:0] i_rd,
    input  logic [river_lite_pkg::XLEN-1:0]          i_imm,
    input  logic                                     i_use_imm,
    input  river_lite_pkg::alu_op_e                  i_alu_op,
    input  logic                                     i_is_store,
    output logic [river_lite_pkg::REG_ADDR_BITS-1:0] o_rs1_addr,
    output logic [river_lite_pkg::REG_ADDR_BITS-1:0] o_rs2_addr,
    input  logic [river_lite_pkg::XLEN-1:0]          i_rs1_data,
    input  logic [river_lite_pkg::XLEN-1:0]          i_rs2_data,
    output logic                                     o_ex_valid,
    output logic [river_lite_pkg::REG_ADDR_BITS-1:0] o_rd,
    output logic [river_lite_pkg::XLEN-1:0]          o_result,
    output logic [river_lite_pkg::XLEN-1:0]          o_store_addr,
    output logic [river_lite_pkg::XLEN-1:0]          o_store_data,
    output logic                                     o_is_store
);

import river_lite_pkg::*;

logic [XLEN-1:0] op_b;
logic [XLEN-1:0] alu_out;

assign o_rs1_addr = i_rs1;   // Register file read is combinational
assign o_rs2_addr = i_rs2;

assign op_b = i_use_imm ? i_imm : i_rs2_data;

always_comb
begin
    case (i_alu_op)
    ALU_ADD:    alu_out = i_rs1_data + op_b;
    ALU_SUB:    alu_out = i_rs1_data - op_b;
    ALU_AND:    alu_out = i_rs1_data & op_b;
    ALU_OR:     alu_out = i_rs1_data | op_b;
    ALU_XOR:    alu_out = i_rs1_data ^ op_b;
    ALU_PASS_B: alu_out = op_b;
    default:    alu_out = '0;
    endcase
end

always_ff @(posedge i_clk or negedge i_rst_n)
begin
    if (!i_rst_n)
        o_ex_valid <= 1'b0;
    else
        o_ex_valid <= i_dec_valid;
end

always_ff @(posedge i_clk)
begin
    if (i_dec_valid)
    begin
        o_rd         <= i_rd;
        o_result     <= alu_out;
        o_store_addr <= i_rs1_data + i_imm;  // Word address for SW
        o_store_data <= alu_out;             // rs2 through ALU_PASS_B
        o_is_store   <= i_is_store;
    end
end

endmodule

`default_nettype wire

/* hdl/result_writeback.sv */
// Result stage: register file, write-back of ALU results and the data-path store request
`default_nettype none

module result_writeback
(
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  logic                                     i_ex_valid,
    input  logic [river_lite_pkg::REG_ADDR_BITS-1:0] i_rd,
    input  logic [river_lite_pkg::XLEN-1:0]          i_result,
    input  logic [river_lite_pkg::XLEN-1:0]          i_store_addr,
    input  logic [river_lite_pkg::XLEN-1:0]          i_store_data,
    input  logic                                     i_is_store,
    input  logic [river_lite_pkg::REG_ADDR_BITS-1:0] i_rs1_addr,
    input  logic [river_lite_pkg::REG_ADDR_BITS-1:0] i_rs2_addr,
    output logic [river_lite_pkg::XLEN-1:0]          o_rs1_data,
    output logic [river_lite_pkg::XLEN-1:0]          o_rs2_data,
    input  logic                                     i_req_data_ready,
    output logic                                     o_req_data_valid,
    output logic [river_lite_pkg::XLEN-1:0]          o_req_data_addr,
    output logic [river_lite_pkg::XLEN-1:0]          o_req_data_wdata,
    output logic                                     o_wb_done
);

import river_lite_pkg::*;

logic [XLEN-1:0] regs [1:31];   // x0 is not stored
logic            alu_done;
logic            store_accept;

// x0 reads as zero
assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

always_ff @(posedge i_clk)
begin
    if (i_ex_valid && !i_is_store && (i_rd != '0))
        regs[i_rd] <= i_result;
end

assign store_accept = o_req_data_valid & i_req_data_ready;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        alu_done         <= 1'b0;
        o_req_data_valid <= 1'b0;
    end
    else
    begin
        alu_done <= i_ex_valid & ~i_is_store;
        if (i_ex_valid && i_is_store)
            o_req_data_valid <= 1'b1;
        else if (store_accept)
            o_req_data_valid <= 1'b0;
    end
end

// Store payload, held until the request is taken
always_ff @(posedge i_clk)
begin
    if (i_ex_valid && i_is_store)
    begin
        o_req_data_addr  <= i_store_addr;
        o_req_data_wdata <= i_store_data;
    end
end

// A store finishes on its handshake cycle, no response expected
assign o_wb_done = alu_done | store_accept;

a_store_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_req_data_valid && !i_req_data_ready |=>
        o_req_data_valid && $stable(o_req_data_addr) && $stable(o_req_data_wdata));

endmodule

`default_nettype wire

/* hdl/river_lite_top.sv */
// Core top level: connects fetch, decode, execute and result stages to the control and data paths
`default_nettype none

module river_lite_top
(
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    // Control path, instruction fetch
    input  logic                             i_req_ctrl_ready,
    output logic                             o_req_ctrl_valid,
    output logic [river_lite_pkg::XLEN-1:0]  o_req_ctrl_addr,
    input  logic                             i_resp_ctrl_valid,
    input  logic [river_lite_pkg::XLEN-1:0]  i_resp_ctrl_data,
    output logic                             o_resp_ctrl_ready,
    // Data path, word stores only
    input  logic                             i_req_data_ready,
    output logic                             o_req_data_valid,
    output logic [river_lite_pkg::XLEN-1:0]  o_req_data_addr,
    output logic [river_lite_pkg::XLEN-1:0]  o_req_data_wdata,
    output logic                             o_halted
);

import river_lite_pkg::*;

logic                     w_instr_valid;
logic [XLEN-1:0]          wb_instr_word;
logic                     w_dec_valid;
logic [REG_ADDR_BITS-1:0] wb_dec_rs1;
logic [REG_ADDR_BITS-1:0] wb_dec_rs2;
logic [REG_ADDR_BITS-1:0] wb_dec_rd;
logic [XLEN-1:0]          wb_dec_imm;
logic                     w_dec_use_imm;
alu_op_e                  wb_dec_alu_op;
logic                     w_dec_is_store;
logic                     w_illegal;
logic [REG_ADDR_BITS-1:0] wb_rs1_addr;
logic [REG_ADDR_BITS-1:0] wb_rs2_addr;
logic [XLEN-1:0]          wb_rs1_data;
logic [XLEN-1:0]          wb_rs2_data;
logic                     w_ex_valid;
logic [REG_ADDR_BITS-1:0] wb_ex_rd;
logic [XLEN-1:0]          wb_ex_result;
logic [XLEN-1:0]          wb_ex_store_addr;
logic [XLEN-1:0]          wb_ex_store_data;
logic                     w_ex_is_store;
logic                     w_wb_done;

fetch_unit u_fetch (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_req_ctrl_ready(i_req_ctrl_ready),
    .o_req_ctrl_valid(o_req_ctrl_valid),
    .o_req_ctrl_addr(o_req_ctrl_addr),
    .i_resp_ctrl_valid(i_resp_ctrl_valid),
    .i_resp_ctrl_data(i_resp_ctrl_data),
    .o_resp_ctrl_ready(o_resp_ctrl_ready),
    .o_instr_valid(w_instr_valid),
    .o_instr_word(wb_instr_word),
    .i_wb_done(w_wb_done),
    .i_illegal(w_illegal),
    .o_halted(o_halted)
);

instr_decode u_decode (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_instr_valid(w_instr_valid),
    .i_instr_word(wb_instr_word),
    .o_dec_valid(w_dec_valid),
    .o_rs1(wb_dec_rs1),
    .o_rs2(wb_dec_rs2),
    .o_rd(wb_dec_rd),
    .o_imm(wb_dec_imm),
    .o_use_imm(w_dec_use_imm),
    .o_alu_op(wb_dec_alu_op),
    .o_is_store(w_dec_is_store),
    .o_illegal(w_illegal)
);

int_execute u_execute (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_dec_valid(w_dec_valid),
    .i_rs1(wb_dec_rs1),
    .i_rs2(wb_dec_rs2),
    .i_rd(wb_dec_rd),
    .i_imm(wb_dec_imm),
    .i_use_imm(w_dec_use_imm),
    .i_alu_op(wb_dec_alu_op),
    .i_is_store(w_dec_is_store),
    .o_rs1_addr(wb_rs1_addr),
    .o_rs2_addr(wb_rs2_addr),
    .i_rs1_data(wb_rs1_data),
    .i_rs2_data(wb_rs2_data),
    .o_ex_valid(w_ex_valid),
    .o_rd(wb_ex_rd),
    .o_result(wb_ex_result),
    .o_store_addr(wb_ex_store_addr),
    .o_store_data(wb_ex_store_data),
    .o_is_store(w_ex_is_store)
);

result_writeback u_result (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_ex_valid(w_ex_valid),
    .i_rd(wb_ex_rd),
    .i_result(wb_ex_result),
    .i_store_addr(wb_ex_store_addr),
    .i_store_data(wb_ex_store_data),
    .i_is_store(w_ex_is_store),
    .i_rs1_addr(wb_rs1_addr),
    .i_rs2_addr(wb_rs2_addr),
    .o_rs1_data(wb_rs1_data),
    .o_rs2_data(wb_rs2_data),
    .i_req_data_ready(i_req_data_ready),
    .o_req_data_valid(o_req_data_valid),
    .o_req_data_addr(o_req_data_addr),
    .o_req_data_wdata(o_req_data_wdata),
    .o_wb_done(w_wb_done)
);

endmodule

`default_nettype wire

/* sim/tb_river_lite.sv */
// Testbench for river_lite_top: program memory model, store responder, reference model and checks
`default_nettype none

module tb_river_lite;

import river_lite_pkg::*;

localparam int PROG_LEN    = 24;
localparam int NUM_STORES  = 10;
localparam int CYCLE_LIMIT = 40 * PROG_LEN + 100;

logic            i_clk             = 1'b0;
logic            i_rst_n           = 1'b0;
logic            i_req_ctrl_ready  = 1'b0;
logic            i_resp_ctrl_valid = 1'b0;
logic [XLEN-1:0] i_resp_ctrl_data  = '0;
logic            i_req_data_ready  = 1'b0;
logic            o_req_ctrl_valid;
logic [XLEN-1:0] o_req_ctrl_addr;
logic            o_resp_ctrl_ready;
logic            o_req_data_valid;
logic [XLEN-1:0] o_req_data_addr;
logic [XLEN-1:0] o_req_data_wdata;
logic            o_halted;

integer          seed = 279;
logic [XLEN-1:0] prog [0:31];
logic [XLEN-1:0] ref_x [0:31] = '{default: '0};   // Reference register file
logic [XLEN-1:0] exp_pc = RESET_PC;
logic [XLEN-1:0] exp_addr_q [$];
logic [XLEN-1:0] exp_data_q [$];
logic            halt_expected = 1'b0;
logic [XLEN-1:0] resp_word = '0;
int              resp_delay = 0;
logic            resp_armed = 1'b0;
int              stores_seen = 0;
logic            data_hold = 1'b0;
logic [XLEN-1:0] data_held_addr = '0;
logic [XLEN-1:0] data_held_wdata = '0;
logic            ctrl_hold = 1'b0;
logic [XLEN-1:0] ctrl_held_addr = '0;
int              cycle_count = 0;
int              halt_cycles = 0;

river_lite_top u_river_lite_top (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_req_ctrl_ready(i_req_ctrl_ready),
    .o_req_ctrl_valid(o_req_ctrl_valid),
    .o_req_ctrl_addr(o_req_ctrl_addr),
    .i_resp_ctrl_valid(i_resp_ctrl_valid),
    .i_resp_ctrl_data(i_resp_ctrl_data),
    .o_resp_ctrl_ready(o_resp_ctrl_ready),
    .i_req_data_ready(i_req_data_ready),
    .o_req_data_valid(o_req_data_valid),
    .o_req_data_addr(o_req_data_addr),
    .o_req_data_wdata(o_req_data_wdata),
    .o_halted(o_halted)
);

always #20 i_clk = ~i_clk;

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
endtask

task automatic check_word(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    assert (got == exp)
    else abort_run($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got == exp)
    else abort_run($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
endtask

function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    rand_below = (r & 32'h7FFF_FFFF) % n;
endfunction

// Opcode field all ones, so stray fetches decode as illegal
function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
    fill_word = (addr * 32'h9E37_79B1) | 32'h0000_007F;
endfunction

function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
    if (addr[31:7] == '0)
        fetch_word = prog[addr[6:2]];
    else
        fetch_word = fill_word(addr);
endfunction

function automatic logic [XLEN-1:0] op_imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [11:0] imm);
    op_imm_word = {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic logic [XLEN-1:0] op_reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
    op_reg_word = {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [XLEN-1:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
    store_word = {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
endfunction

function automatic logic [XLEN-1:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    lui_word = {imm, rd, OPC_LUI};
endfunction

// Executes one fetched word by the RV32I rules of the subset
task automatic run_reference(input logic [XLEN-1:0] w);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] res;
    logic            wr;
    logic            legal;
    a     = ref_x[w[19:15]];
    b     = ref_x[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    res   = '0;
    wr    = 1'b1;
    legal = 1'b1;
    case (w[6:0])
    OPC_OP_IMM:
        case (w[14:12])
        3'b000:  res = a + imm_i;
        3'b100:  res = a ^ imm_i;
        3'b110:  res = a | imm_i;
        3'b111:  res = a & imm_i;
        default: legal = 1'b0;
        endcase
    OPC_OP:
        case ({w[31:25], w[14:12]})
        10'b0000000_000: res = a + b;
        10'b0100000_000: res = a - b;
        10'b0000000_100: res = a ^ b;
        10'b0000000_110: res = a | b;
        10'b0000000_111: res = a & b;
        default:         legal = 1'b0;
        endcase
    OPC_LUI: res = {w[31:12], 12'h000};
    OPC_STORE:
    begin
        wr = 1'b0;
        if (w[14:12] == 3'b010)
        begin
            exp_addr_q.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
            exp_data_q.push_back(b);
        end
        else
            legal = 1'b0;
    end
    default: legal = 1'b0;
    endcase
    if (!legal)
        halt_expected = 1'b1;
    else if (wr && w[11:7] != 5'd0)
        ref_x[w[11:7]] = res;   // x0 stays zero
endtask

initial
begin
    for (int i = 0; i < 32; i++)
        prog[i] = fill_word(i * 4);
    prog[0]  = op_imm_word(F3_ADD, 5'd1, 5'd0, 12'h123);
    prog[1]  = op_imm_word(F3_ADD, 5'd2, 5'd0, 12'hF10);   // Negative immediate
    prog[2]  = op_reg_word(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2);
    prog[3]  = store_word(5'd3, 5'd0, 12'h100);
    prog[4]  = op_reg_word(F7_SUB, F3_ADD, 5'd4, 5'd1, 5'd2);
    prog[5]  = store_word(5'd4, 5'd0, 12'h104);
    prog[6]  = op_reg_word(F7_BASE, F3_AND, 5'd5, 5'd1, 5'd2);
    prog[7]  = store_word(5'd5, 5'd0, 12'h108);
    prog[8]  = op_reg_word(F7_BASE, F3_OR, 5'd6, 5'd1, 5'd2);
    prog[9]  = store_word(5'd6, 5'd0, 12'h10C);
    prog[10] = op_reg_word(F7_BASE, F3_XOR, 5'd7, 5'd1, 5'd2);
    prog[11] = store_word(5'd7, 5'd0, 12'h110);
    prog[12] = op_imm_word(F3_AND, 5'd8, 5'd3, 12'h0FF);
    prog[13] = store_word(5'd8, 5'd0, 12'h114);
    prog[14] = op_imm_word(F3_OR, 5'd9, 5'd4, 12'h700);
    prog[15] = store_word(5'd9, 5'd0, 12'h118);
    prog[16] = op_imm_word(F3_XOR, 5'd10, 5'd5, 12'hFFF);
    prog[17] = store_word(5'd10, 5'd0, 12'h11C);
    prog[18] = lui_word(5'd11, 20'hABCDE);
    prog[19] = op_imm_word(F3_ADD, 5'd12, 5'd0, 12'h200);
    prog[20] = store_word(5'd11, 5'd12, 12'hFFC);          // Base minus 4
    prog[21] = op_imm_word(F3_ADD, 5'd0, 5'd1, 12'h005);   // Write to x0
    prog[22] = store_word(5'd0, 5'd12, 12'h020);
    prog[23] = 32'h0000_0000;                              // Undefined opcode
    repeat (4) @(posedge i_clk);
    i_rst_n <= 1'b1;
end

// Program memory, answers each accepted request after 0 to 3 cycles
// Random ready for both request paths
always @(posedge i_clk)
begin
    if (i_rst_n)
    begin
        i_req_ctrl_ready <= (rand_below(2) == 1);
        i_req_data_ready <= (rand_below(3) == 0);
        if (o_resp_ctrl_ready && i_resp_ctrl_valid)
        begin
            i_resp_ctrl_valid <= 1'b0;
            run_reference(i_resp_ctrl_data);
        end
        if (o_req_ctrl_valid && i_req_ctrl_ready)
        begin
            assert (!halt_expected)
            else abort_run("Control request issued after the illegal instruction");
            check_word("o_req_ctrl_addr", o_req_ctrl_addr, exp_pc);
            exp_pc     = exp_pc + 32'd4;
            resp_word  = fetch_word(o_req_ctrl_addr);
            resp_delay = rand_below(4);
            resp_armed = 1'b1;
        end
        if (resp_armed)
        begin
            if (resp_delay == 0)
            begin
                i_resp_ctrl_valid <= 1'b1;
                i_resp_ctrl_data  <= resp_word;
                resp_armed = 1'b0;
            end
            else
                resp_delay = resp_delay - 1;
        end
    end
end

// Store requests against the reference model
always @(posedge i_clk)
begin
    if (i_rst_n)
    begin
        if (data_hold)
        begin
            check_bit("o_req_data_valid", o_req_data_valid, 1'b1);
            check_word("o_req_data_addr", o_req_data_addr, data_held_addr);
            check_word("o_req_data_wdata", o_req_data_wdata, data_held_wdata);
        end
        if (o_req_data_valid)
            check_bit("o_req_ctrl_valid", o_req_ctrl_valid, 1'b0);  // One in flight
        if (o_req_data_valid && i_req_data_ready)
        begin
            assert (exp_data_q.size() > 0)
            else abort_run("Store request seen with no store predicted");
            check_word("o_req_data_addr", o_req_data_addr, exp_addr_q.pop_front());
            check_word("o_req_data_wdata", o_req_data_wdata, exp_data_q.pop_front());
            stores_seen = stores_seen + 1;
        end
        data_hold       = o_req_data_valid && !i_req_data_ready;
        data_held_addr  = o_req_data_addr;
        data_held_wdata = o_req_data_wdata;
    end
end

// Reset state, request stability, halt and end of run
always @(posedge i_clk)
begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 2 && cycle_count <= 5)
    begin
        check_bit("o_req_data_valid", o_req_data_valid, 1'b0);
        check_bit("o_resp_ctrl_ready", o_resp_ctrl_ready, 1'b0);
        check_bit("o_halted", o_halted, 1'b0);
    end
    if (ctrl_hold)
    begin
        check_bit("o_req_ctrl_valid", o_req_ctrl_valid, 1'b1);
        check_word("o_req_ctrl_addr", o_req_ctrl_addr, ctrl_held_addr);
    end
    ctrl_hold      = i_rst_n && o_req_ctrl_valid && !i_req_ctrl_ready;
    ctrl_held_addr = o_req_ctrl_addr;
    if (o_halted)
    begin
        assert (halt_expected)
        else abort_run("o_halted rose although no illegal instruction was fetched");
        check_bit("o_req_ctrl_valid", o_req_ctrl_valid, 1'b0);
        if (halt_cycles == 0)
        begin
            check_word("stores_seen", stores_seen, NUM_STORES);
            check_word("pending_stores", exp_addr_q.size(), 0);
        end
        halt_cycles = halt_cycles + 1;
    end
    if (cycle_count >= CYCLE_LIMIT)
        abort_run("Timeout: the core did not halt within the cycle limit");
    else if (halt_cycles == 8)
    begin
        $display("Result: PASSED");
        $finish;
    end
end

endmodule

`default_nettype wire

/* river_lite.f */
hdl/river_lite_pkg.sv
hdl/fetch_unit.sv
hdl/instr_decode.sv
hdl/int_execute.sv
hdl/result_writeback.sv
hdl/river_lite_top.sv
sim/tb_river_lite.sv

/* run_sim.sh */
#!/bin/sh
# Builds the river_lite testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_river_lite \
    -f river_lite.f

./obj_dir/Vtb_river_lite 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
